/* rv_decode_pkg.sv */
package rv_decode_pkg;

   // data and address width of the core.
   parameter int unsigned xlen = 32;

   typedef logic [xlen-1:0] word_t;
   typedef logic [4:0]      reg_addr_t;

   typedef enum logic [5:0] {
      ADD,
      ADDI,
      AND,
      ANDI,
      AUIPC,
      BEQ,
      BGE,
      BGEU,
      BLT,
      BLTU,
      BNE,
      EBREAK,
      ECALL,
      FENCE,
      JAL,
      JALR,
      LB,
      LBU,
      LH,
      LHU,
      LUI,
      LW,
      OR,
      ORI,
      SB,
      SH,
      SLL,
      SLT,
      SLTI,
      SLTIU,
      SLTU,
      SRA,
      SRL,
      SUB,
      SW,
      XOR,
      XORI,
      ILLEGAL
   } op_t;

   // immediate layouts of the base integer encoding.
   typedef enum logic [2:0] {
      imm_none,
      imm_i,
      imm_s,
      imm_b,
      imm_u,
      imm_j
   } imm_fmt_t;

endpackage : rv_decode_pkg

/* rv_opcode_decoder.sv */
module rv_opcode_decoder
   import rv_decode_pkg::*;
(
   input  word_t    instr,
   output op_t      op,
   output imm_fmt_t imm_fmt,
   output logic     rd_used,
   output logic     rs1_used,
   output logic     rs2_used
);

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic       r_type;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   // the full 7-bit opcode match also rejects every word whose low bits are not 11.
   always_comb begin
      op      = ILLEGAL;
      imm_fmt = imm_none;
      r_type  = 1'b0;
      case (opcode)
         7'b0110111: begin
            op      = LUI;
            imm_fmt = imm_u;
         end
         7'b0010111: begin
            op      = AUIPC;
            imm_fmt = imm_u;
         end
         7'b1101111: begin
            op      = JAL;
            imm_fmt = imm_j;
         end
         7'b1100111: begin
            if (funct3 == 3'b000) begin
               op      = JALR;
               imm_fmt = imm_i;
            end
         end
         7'b1100011: begin
            imm_fmt = imm_b;
            case (funct3)
               3'b000:  op = BEQ;
               3'b001:  op = BNE;
               3'b100:  op = BLT;
               3'b101:  op = BGE;
               3'b110:  op = BLTU;
               3'b111:  op = BGEU;
               default: imm_fmt = imm_none;
            endcase
         end
         7'b0000011: begin
            imm_fmt = imm_i;
            case (funct3)
               3'b000:  op = LB;
               3'b001:  op = LH;
               3'b010:  op = LW;
               3'b100:  op = LBU;
               3'b101:  op = LHU;
               default: imm_fmt = imm_none;
            endcase
         end
         7'b0100011: begin
            imm_fmt = imm_s;
            case (funct3)
               3'b000:  op = SB;
               3'b001:  op = SH;
               3'b010:  op = SW;
               default: imm_fmt = imm_none;
            endcase
         end
         7'b0010011: begin
            // shift-immediate forms (funct3 001 and 101) are not in the operation list.
            imm_fmt = imm_i;
            case (funct3)
               3'b000:  op = ADDI;
               3'b010:  op = SLTI;
               3'b011:  op = SLTIU;
               3'b100:  op = XORI;
               3'b110:  op = ORI;
               3'b111:  op = ANDI;
               default: imm_fmt = imm_none;
            endcase
         end
         7'b0110011: begin
            r_type = 1'b1;
            case ({funct7, funct3})
               {7'b0000000, 3'b000}: op = ADD;
               {7'b0100000, 3'b000}: op = SUB;
               {7'b0000000, 3'b001}: op = SLL;
               {7'b0000000, 3'b010}: op = SLT;
               {7'b0000000, 3'b011}: op = SLTU;
               {7'b0000000, 3'b100}: op = XOR;
               {7'b0000000, 3'b101}: op = SRL;
               {7'b0100000, 3'b101}: op = SRA;
               {7'b0000000, 3'b110}: op = OR;
               {7'b0000000, 3'b111}: op = AND;
               default:              r_type = 1'b0;
            endcase
         end
         7'b0001111: begin
            if (funct3 == 3'b000) begin
               op = FENCE;
            end
         end
         7'b1110011: begin
            if (instr == 32'h0000_0073) begin
               op = ECALL;
            end else if (instr == 32'h0010_0073) begin
               op = EBREAK;
            end
         end
         default: begin
            op = ILLEGAL;
         end
      endcase
   end

   // register use follows the instruction format.
   assign rd_used  = r_type | (imm_fmt inside {imm_i, imm_u, imm_j});
   assign rs1_used = r_type | (imm_fmt inside {imm_i, imm_s, imm_b});
   assign rs2_used = r_type | (imm_fmt inside {imm_s, imm_b});

endmodule : rv_opcode_decoder

/* rv_immediate_gen.sv */
module rv_immediate_gen
   import rv_decode_pkg::*;
(
   input  word_t    instr,
   input  imm_fmt_t imm_fmt,
   output word_t    immed
);

   word_t immed_i;
   word_t immed_s;
   word_t immed_b;
   word_t immed_u;
   word_t immed_j;

   // all signed layouts take their sign from bit 31.
   assign immed_i = {{20{instr[31]}}, instr[31:20]};
   assign immed_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immed_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immed_u = {instr[31:12], 12'b0};
   assign immed_j = {
      {11{instr[31]}},
      instr[31],
      instr[19:12],
      instr[20],
      instr[30:21],
      1'b0
   };

   always_comb begin
      case (imm_fmt)
         imm_i:   immed = immed_i;
         imm_s:   immed = immed_s;
         imm_b:   immed = immed_b;
         imm_u:   immed = immed_u;
         imm_j:   immed = immed_j;
         default: immed = '0;
      endcase
   end

endmodule : rv_immediate_gen

/* rv_decode_register.sv */
module rv_decode_register
   import rv_decode_pkg::*;
#(
   parameter int unsigned seq_width = 64
) (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 ifu_valid,
   input  word_t                ifu_addr,
   input  word_t                ifu_instr,
   input  op_t                  op,
   input  logic                 rd_used,
   input  logic                 rs1_used,
   input  logic                 rs2_used,
   input  word_t                immed,
   output logic                 idu_valid,
   output logic [seq_width-1:0] idu_seq,
   output word_t                idu_addr,
   output word_t                idu_addr_next,
   output word_t                idu_instr,
   output op_t                  idu_op,
   output reg_addr_t            idu_rd,
   output reg_addr_t            idu_rs1,
   output reg_addr_t            idu_rs2,
   output logic                 idu_rd_used,
   output logic                 idu_rs1_used,
   output logic                 idu_rs2_used,
   output word_t                idu_immed
);

   logic [seq_width-1:0] seq_count;
   word_t                addr_next;

   // only full-width instructions exist, so the next address is always plus 4.
   assign addr_next = ifu_addr + word_t'(4);

   always_ff @(posedge clock) begin
      if (reset) begin
         idu_valid <= 1'b0;
         idu_seq   <= '0;
         seq_count <= '0;
      end else begin
         idu_valid <= ifu_valid;
         if (ifu_valid) begin
            // the record carries the count of instructions accepted before it.
            idu_seq   <= seq_count;
            seq_count <= seq_count + seq_width'(1);
         end
      end
   end

   // record fields hold their last value between strobes.
   always_ff @(posedge clock) begin
      if (ifu_valid) begin
         idu_addr      <= ifu_addr;
         idu_addr_next <= addr_next;
         idu_instr     <= ifu_instr;
         idu_op        <= op;
         idu_rd        <= ifu_instr[11:7];
         idu_rs1       <= ifu_instr[19:15];
         idu_rs2       <= ifu_instr[24:20];
         idu_rd_used   <= rd_used;
         idu_rs1_used  <= rs1_used;
         idu_rs2_used  <= rs2_used;
         idu_immed     <= immed;
      end
   end

endmodule : rv_decode_register

/* rv_idu.sv */
module rv_idu
   import rv_decode_pkg::*;
#(
   parameter int unsigned seq_width = 64
) (
   input  logic                 clock,
   input  logic                 reset,
   input  logic                 ifu_valid,
   input  word_t                ifu_addr,
   input  word_t                ifu_instr,
   output logic                 idu_valid,
   output logic [seq_width-1:0] idu_seq,
   output word_t                idu_addr,
   output word_t                idu_addr_next,
   output word_t                idu_instr,
   output op_t                  idu_op,
   output reg_addr_t            idu_rd,
   output reg_addr_t            idu_rs1,
   output reg_addr_t            idu_rs2,
   output logic                 idu_rd_used,
   output logic                 idu_rs1_used,
   output logic                 idu_rs2_used,
   output word_t                idu_immed
);

   op_t      op;
   imm_fmt_t imm_fmt;
   logic     rd_used;
   logic     rs1_used;
   logic     rs2_used;
   word_t    immed;

   rv_opcode_decoder rv_opcode_decoder_i (
      .instr   (ifu_instr),
      .op      (op),
      .imm_fmt (imm_fmt),
      .rd_used (rd_used),
      .rs1_used(rs1_used),
      .rs2_used(rs2_used)
   );

   rv_immediate_gen rv_immediate_gen_i (
      .instr  (ifu_instr),
      .imm_fmt(imm_fmt),
      .immed  (immed)
   );

   rv_decode_register #(
      .seq_width(seq_width)
   ) rv_decode_register_i (
      .clock        (clock),
      .reset        (reset),
      .ifu_valid    (ifu_valid),
      .ifu_addr     (ifu_addr),
      .ifu_instr    (ifu_instr),
      .op           (op),
      .rd_used      (rd_used),
      .rs1_used     (rs1_used),
      .rs2_used     (rs2_used),
      .immed        (immed),
      .idu_valid    (idu_valid),
      .idu_seq      (idu_seq),
      .idu_addr     (idu_addr),
      .idu_addr_next(idu_addr_next),
      .idu_instr    (idu_instr),
      .idu_op       (idu_op),
      .idu_rd       (idu_rd),
      .idu_rs1      (idu_rs1),
      .idu_rs2      (idu_rs2),
      .idu_rd_used  (idu_rd_used),
      .idu_rs1_used (idu_rs1_used),
      .idu_rs2_used (idu_rs2_used),
      .idu_immed    (idu_immed)
   );

endmodule : rv_idu

/* rv_idu_tb.sv */
module rv_idu_tb
   import rv_decode_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   typedef struct packed {
      op_t       op;
      logic      rd_used;
      logic      rs1_used;
      logic      rs2_used;
      word_t     immed;
      word_t     addr;
      word_t     addr_next;
      word_t     instr;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
   } rec_t;

   // one {funct7, funct3, opcode} key per operation, grouped by instruction class.
   localparam logic [16:0] op_keys [35] = '{
      17'h00037, 17'h00017, 17'h0006f, 17'h00067,
      17'h00063, 17'h000e3, 17'h00263, 17'h002e3, 17'h00363, 17'h003e3,
      17'h00003, 17'h00083, 17'h00103, 17'h00203, 17'h00283,
      17'h00023, 17'h000a3, 17'h00123,
      17'h00013, 17'h00113, 17'h00193, 17'h00213, 17'h00313, 17'h00393,
      17'h00033, 17'h08033, 17'h000b3, 17'h00133, 17'h001b3,
      17'h00233, 17'h002b3, 17'h082b3, 17'h00333, 17'h003b3,
      17'h0000f
   };

   // shift-immediate, multiply, bad funct7, bad funct3 and a non-zero ECALL.
   localparam word_t illegal_words [10] = '{
      32'h0031_1093, 32'h0031_5093, 32'h4031_5093, 32'h0231_00b3, 32'h0231_40b3,
      32'h0231_70b3, 32'h4031_10b3, 32'h8031_00b3, 32'h0031_2063, 32'h0000_00f3
   };

   // operations indexed by funct3 for each opcode class.
   localparam op_t branch_ops [8] = '{BEQ, BNE, ILLEGAL, ILLEGAL, BLT, BGE, BLTU, BGEU};
   localparam op_t load_ops [8] = '{LB, LH, LW, ILLEGAL, LBU, LHU, ILLEGAL, ILLEGAL};
   localparam op_t store_ops [8] = '{SB, SH, SW, ILLEGAL, ILLEGAL, ILLEGAL, ILLEGAL, ILLEGAL};
   localparam op_t alui_ops [8] = '{ADDI, ILLEGAL, SLTI, SLTIU, XORI, ILLEGAL, ORI, ANDI};
   localparam op_t alu_ops [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
   localparam op_t alu_alt_ops [8] = '{SUB, ILLEGAL, ILLEGAL, ILLEGAL, ILLEGAL, SRA, ILLEGAL,
                                       ILLEGAL};

   logic        clock;
   logic        reset;
   logic        ifu_valid;
   word_t       ifu_addr;
   word_t       ifu_instr;
   logic        idu_valid;
   logic [63:0] idu_seq;
   word_t       idu_addr;
   word_t       idu_addr_next;
   word_t       idu_instr;
   op_t         idu_op;
   reg_addr_t   idu_rd;
   reg_addr_t   idu_rs1;
   reg_addr_t   idu_rs2;
   logic        idu_rd_used;
   logic        idu_rs1_used;
   logic        idu_rs2_used;
   word_t       idu_immed;

   int          seed = 37;
   int          check_count = 0;
   int          error_count = 0;
   int          errors_before = 0;
   int          sent_count = 0;
   int          rec_count = 0;
   logic        timed_out = 1'b0;
   logic        strobe_pending = 1'b0;
   logic        have_last = 1'b0;
   logic [63:0] exp_seq = '0;
   rec_t        last_rec;
   rec_t        expect_q [$];

   rv_idu #(
      .seq_width(64)
   ) rv_idu_i (.*);

   always #2 clock = ~clock;

   function automatic rec_t ref_decode(input word_t instr, input word_t addr);
      rec_t       r;
      imm_fmt_t   fmt;
      logic       rtype;
      logic [2:0] f3;
      r = '0;
      f3 = instr[14:12];
      case (instr[6:0])
         7'h37:   r.op = LUI;
         7'h17:   r.op = AUIPC;
         7'h6f:   r.op = JAL;
         7'h67:   r.op = (f3 == 3'd0) ? JALR : ILLEGAL;
         7'h63:   r.op = branch_ops[f3];
         7'h03:   r.op = load_ops[f3];
         7'h23:   r.op = store_ops[f3];
         7'h13:   r.op = alui_ops[f3];
         7'h33:   r.op = (instr[31:25] == 7'h00) ? alu_ops[f3] :
                         (instr[31:25] == 7'h20) ? alu_alt_ops[f3] : ILLEGAL;
         7'h0f:   r.op = (f3 == 3'd0) ? FENCE : ILLEGAL;
         7'h73:   r.op = (instr == 32'h0000_0073) ? ECALL :
                         (instr == 32'h0010_0073) ? EBREAK : ILLEGAL;
         default: r.op = ILLEGAL;
      endcase
      case (instr[6:0])
         7'h37, 7'h17:        fmt = imm_u;
         7'h6f:               fmt = imm_j;
         7'h63:               fmt = imm_b;
         7'h23:               fmt = imm_s;
         7'h67, 7'h03, 7'h13: fmt = imm_i;
         default:             fmt = imm_none;
      endcase
      if (r.op == ILLEGAL) begin
         fmt = imm_none;
      end
      rtype = (instr[6:0] == 7'h33) && (r.op != ILLEGAL);
      // rd, rs1 and rs2 use per instruction format.
      if (rtype) begin
         {r.rd_used, r.rs1_used, r.rs2_used} = 3'b111;
      end else begin
         case (fmt)
            imm_i:        {r.rd_used, r.rs1_used, r.rs2_used} = 3'b110;
            imm_s, imm_b: {r.rd_used, r.rs1_used, r.rs2_used} = 3'b011;
            imm_u, imm_j: {r.rd_used, r.rs1_used, r.rs2_used} = 3'b100;
            default:      {r.rd_used, r.rs1_used, r.rs2_used} = 3'b000;
         endcase
      end
      case (fmt)
         imm_i:   r.immed = word_t'($signed(instr) >>> 20);
         imm_s:   r.immed = (word_t'($signed(instr) >>> 25) << 5) | word_t'(instr[11:7]);
         imm_b:   r.immed = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
         imm_u:   r.immed = instr & 32'hffff_f000;
         imm_j:   r.immed = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
         default: r.immed = '0;
      endcase
      r.addr      = addr;
      r.addr_next = addr + 32'd4;
      r.instr     = instr;
      r.rd        = instr[11:7];
      r.rs1       = instr[19:15];
      r.rs2       = instr[24:20];
      return r;
   endfunction

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      check_count++;
      if (actual !== expected) begin
         $display("** Error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, actual,
                  expected);
         error_count++;
      end
   endtask

   task automatic compare_record(input rec_t r, input logic [63:0] seq);
      check_value(idu_seq, seq, "idu_seq");
      check_value(64'(idu_addr), 64'(r.addr), "idu_addr");
      check_value(64'(idu_addr_next), 64'(r.addr_next), "idu_addr_next");
      check_value(64'(idu_instr), 64'(r.instr), "idu_instr");
      check_value(64'(idu_op), 64'(r.op), "idu_op");
      check_value(64'(idu_rd), 64'(r.rd), "idu_rd");
      check_value(64'(idu_rs1), 64'(r.rs1), "idu_rs1");
      check_value(64'(idu_rs2), 64'(r.rs2), "idu_rs2");
      check_value(64'(idu_rd_used), 64'(r.rd_used), "idu_rd_used");
      check_value(64'(idu_rs1_used), 64'(r.rs1_used), "idu_rs1_used");
      check_value(64'(idu_rs2_used), 64'(r.rs2_used), "idu_rs2_used");
      check_value(64'(idu_immed), 64'(r.immed), "idu_immed");
   endtask

   // outputs are sampled mid-cycle, and the inputs seen here are the ones the next edge captures.
   always @(negedge clock) begin
      if (!reset) begin
         check_value(64'(idu_valid), 64'(strobe_pending), "idu_valid");
         if (idu_valid && expect_q.size() != 0) begin
            last_rec = expect_q.pop_front();
            compare_record(last_rec, exp_seq);
            exp_seq = exp_seq + 64'd1;
            have_last = 1'b1;
            rec_count++;
         end else if (have_last) begin
            compare_record(last_rec, exp_seq - 64'd1);
         end
         strobe_pending = ifu_valid;
         if (ifu_valid) begin
            expect_q.push_back(ref_decode(ifu_instr, ifu_addr));
         end
      end
   end

   task automatic send_word(input word_t word, input word_t addr);
      @(posedge clock);
      ifu_valid <= 1'b1;
      ifu_instr <= word;
      ifu_addr  <= addr;
      sent_count++;
   endtask

   // idle inputs carry noise so that held record fields are really tested.
   task automatic idle_cycles(input int count);
      repeat (count) begin
         @(posedge clock);
         ifu_valid <= 1'b0;
         ifu_instr <= $random(seed);
         ifu_addr  <= $random(seed);
      end
   endtask

   task automatic wait_drain();
      int cycles;
      idle_cycles(1);
      cycles = 0;
      while (rec_count != sent_count && cycles < 20) begin
         @(posedge clock);
         cycles++;
      end
      if (rec_count != sent_count) begin
         $display("Timeout: only %0d of %0d records arrived", rec_count, sent_count);
         timed_out = 1'b1;
      end
   endtask

   task automatic report_test(input string name);
      $display("test %s finished with %0d errors", name, error_count - errors_before);
      errors_before = error_count;
   endtask

   task automatic run_tests();
      word_t word;
      word_t addr;
      int    gap;
      int    pick;
      rec_t  probe;
      idle_cycles(3);
      @(negedge clock);
      check_value(64'(idu_valid), 64'd0, "idu_valid after reset");
      check_value(idu_seq, 64'd0, "idu_seq after reset");
      send_word(32'h0010_0093, 32'h0000_1000);
      wait_drain();
      report_test("reset_state");
      if (timed_out) return;

      addr = 32'h0000_2000;
      for (int i = 0; i < 35; i++) begin
         word = $random(seed);
         word[6:0] = op_keys[i][6:0];
         if (!(word[6:0] inside {7'h37, 7'h17, 7'h6f})) begin
            word[14:12] = op_keys[i][9:7];
         end
         // the sign bit alternates so every format also sees a negative immediate.
         if (word[6:0] == 7'h33) begin
            word[31:25] = op_keys[i][16:10];
         end else begin
            word[31] = i[0] || (word[6:0] == 7'h6f);
         end
         send_word(word, addr);
         addr = addr + 32'd4;
      end
      send_word(32'h0000_0073, addr);
      send_word(32'h0010_0073, addr + 32'd4);
      wait_drain();
      report_test("directed_ops");
      if (timed_out) return;

      for (int i = 0; i < 13; i++) begin
         word = $random(seed);
         if (i < 3) begin
            word[1:0] = 2'(i);
         end else begin
            word = illegal_words[i - 3];
         end
         probe = ref_decode(word, addr);
         check_value(64'(probe.op), 64'(ILLEGAL), "reference op");
         send_word(word, addr);
      end
      wait_drain();
      report_test("illegal_words");
      if (timed_out) return;

      send_word($random(seed), 32'h0000_0000);
      send_word($random(seed), 32'hffff_fffc);
      send_word($random(seed), 32'h7fff_fffc);
      send_word($random(seed), 32'hffff_fff8);
      wait_drain();
      report_test("addresses");
      if (timed_out) return;

      for (int i = 0; i < 200; i++) begin
         word = $random(seed);
         if (($random(seed) & 3) != 0) begin
            pick = $unsigned($random(seed)) % 35;
            word[6:0] = op_keys[pick][6:0];
         end
         addr = $random(seed);
         addr[1:0] = 2'b00;
         gap = $random(seed) & 3;
         send_word(word, addr);
         idle_cycles(gap);
      end
      wait_drain();
      report_test("random_stream");
      if (timed_out) return;

      send_word($random(seed), 32'h0000_4000);
      idle_cycles(10);
      wait_drain();
      report_test("hold");
   endtask

   initial begin
      clock = 1'b0;
      reset = 1'b1;
      ifu_valid = 1'b0;
      ifu_addr = '0;
      ifu_instr = '0;
      repeat (3) @(posedge clock);
      reset <= 1'b0;
      run_tests();
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (!timed_out && error_count == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule : rv_idu_tb

/* rv_idu.f */
rv_decode_pkg.sv
rv_opcode_decoder.sv
rv_immediate_gen.sv
rv_decode_register.sv
rv_idu.sv
rv_idu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= rv_idu_tb
LINT_TOP  ?= rv_idu
FILELIST  ?= rv_idu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_TEXT ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

clean:
	rm -rf $(BUILD_DIR)
